/* Bender.yml */
package:
  name: memory_system

sources:
  - logic/MemoryMapPackage.sv
  - logic/WordRam.sv
  - logic/BusRouter.sv
  - logic/PeripheralRegisters.sv
  - logic/TimeBase.sv
  - logic/PixelFetch.sv
  - logic/MemorySystem.sv
  - target: test
    files:
      - tb/MemorySystemTb.sv

/* logic/BusRouter.sv */
`timescale 1ns/1ps

module BusRouter (
	input logic clk,
	input logic rst,
	input MemoryMapPackage::Word address,
	input MemoryMapPackage::Word writeData,
	input MemoryMapPackage::AccessMode writeMode,
	input MemoryMapPackage::AccessMode readMode,
	input logic unsignedLoad,
	output MemoryMapPackage::Word dataOut,
	input logic displayBuffer,
	output MemoryMapPackage::Word mainByteAddress,
	output MemoryMapPackage::Word mainWriteData,
	output MemoryMapPackage::AccessMode mainWriteMode,
	output MemoryMapPackage::AccessMode mainReadMode,
	output logic mainUnsignedLoad,
	output MemoryMapPackage::Word vram0ByteAddress,
	output MemoryMapPackage::Word vram0WriteData,
	output MemoryMapPackage::AccessMode vram0WriteMode,
	output MemoryMapPackage::AccessMode vram0ReadMode,
	output logic vram0UnsignedLoad,
	output MemoryMapPackage::Word vram1ByteAddress,
	output MemoryMapPackage::Word vram1WriteData,
	output MemoryMapPackage::AccessMode vram1WriteMode,
	output MemoryMapPackage::AccessMode vram1ReadMode,
	output logic vram1UnsignedLoad,
	input MemoryMapPackage::Word mainReadData,
	input MemoryMapPackage::Word vram0ReadData,
	input MemoryMapPackage::Word vram1ReadData,
	output logic sevenSegWrite,
	output logic resetVectorWrite,
	output logic swapWrite,
	output MemoryMapPackage::Word registerWriteData,
	input MemoryMapPackage::Word sevenSeg,
	input MemoryMapPackage::Word resetVector,
	input logic swapRequest,
	input MemoryMapPackage::Word msCount,
	input MemoryMapPackage::Word usCount
);
	import MemoryMapPackage::*;

	MemRegion region;
	MemRegion regionQ;
	logic writing;
	logic readPendingQ;
	Word vramAddress;

	// Keyboard range and the old PC address decode to nothing
	always_comb begin
		if (address == SevenSegAddr)
			region = regionSevenSeg;
		else if (address == ResetVectorAddr)
			region = regionResetVector;
		else if (address == MsCounterAddr)
			region = regionMsCounter;
		else if (address == UsCounterAddr)
			region = regionUsCounter;
		else if (address == BufferSwapAddr)
			region = regionBufferSwap;
		else if (address >= MainRamBase && address <= MainRamLast)
			region = regionMainRam;
		else if (address >= Vram0Base && address < Vram0Base + VramBytes)
			region = regionVram0;
		else if (address >= Vram1Base && address < Vram1Base + VramBytes)
			region = regionVram1;
		else
			region = regionNone;
	end

	assign writing = (writeMode != modeNone);

	assign sevenSegWrite = writing && (region == regionSevenSeg);
	assign resetVectorWrite = writing && (region == regionResetVector);
	assign swapWrite = writing && (region == regionBufferSwap);
	assign registerWriteData = writeData;

	// Master always lands in the offscreen half
	assign vramAddress = Word'({~displayBuffer, address[10:0]});

	assign mainByteAddress = address;
	assign mainWriteData = writeData;
	assign mainWriteMode = (region == regionMainRam) ? writeMode : modeNone;
	assign mainReadMode = (region == regionMainRam) ? readMode : modeNone;
	assign mainUnsignedLoad = unsignedLoad;

	assign vram0ByteAddress = vramAddress;
	assign vram0WriteData = writeData;
	assign vram0WriteMode = (region == regionVram0) ? writeMode : modeNone;
	assign vram0ReadMode = (region == regionVram0) ? readMode : modeNone;
	assign vram0UnsignedLoad = unsignedLoad;

	assign vram1ByteAddress = vramAddress;
	assign vram1WriteData = writeData;
	assign vram1WriteMode = (region == regionVram1) ? writeMode : modeNone;
	assign vram1ReadMode = (region == regionVram1) ? readMode : modeNone;
	assign vram1UnsignedLoad = unsignedLoad;

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			regionQ <= regionNone;
			readPendingQ <= 1'b0;
		end
		else begin
			regionQ <= region;
			readPendingQ <= (readMode != modeNone);
		end
	end

	// Response for the request of the previous cycle
	always_comb begin
		dataOut = '0;
		if (readPendingQ) begin
			unique case (regionQ)
				regionSevenSeg: dataOut = sevenSeg;
				regionResetVector: dataOut = resetVector;
				regionMsCounter: dataOut = msCount;
				regionUsCounter: dataOut = usCount;
				regionBufferSwap: dataOut = {31'd0, swapRequest};
				regionMainRam: dataOut = mainReadData;
				regionVram0: dataOut = vram0ReadData;
				regionVram1: dataOut = vram1ReadData;
				default: dataOut = '0;
			endcase
		end
	end

endmodule

/* logic/MemoryMapPackage.sv */
package MemoryMapPackage;

	typedef logic [31:0] Word;

	// Byte address inside one half of a video RAM
	typedef logic [10:0] PixelAddr;

	typedef enum logic [2:0] {
		modeNone = 3'd0,
		modeByte = 3'd1,
		modeHalf = 3'd2,
		modeWord = 3'd3
	} AccessMode;

	typedef enum logic [3:0] {
		regionNone,
		regionSevenSeg,
		regionResetVector,
		regionMsCounter,
		regionUsCounter,
		regionBufferSwap,
		regionMainRam,
		regionVram0,
		regionVram1
	} MemRegion;

	// Address map, byte addresses
	localparam Word SevenSegAddr = 32'd255;
	localparam Word ResetVectorAddr = 32'd259;
	localparam Word MsCounterAddr = 32'd267;
	localparam Word UsCounterAddr = 32'd271;
	localparam Word BufferSwapAddr = 32'd275;
	localparam Word MainRamBase = 32'd1024;
	localparam Word MainRamLast = 32'd65535;
	localparam Word Vram0Base = 32'd65536;
	localparam Word Vram1Base = 32'd67584;
	localparam Word VramBytes = 32'd2048;

	localparam Word ResetVectorDefault = 32'h3FC;

endpackage

/* logic/MemorySystem.sv */
`timescale 1ns/1ps

module MemorySystem #(
	parameter int ClockHz = 8333333
) (
	input logic clk,
	input logic rst,
	input MemoryMapPackage::Word address,
	input MemoryMapPackage::Word writeData,
	input MemoryMapPackage::AccessMode writeMode,
	input MemoryMapPackage::AccessMode readMode,
	input logic unsignedLoad,
	output MemoryMapPackage::Word dataOut,
	input logic frameDone,
	input MemoryMapPackage::PixelAddr pixelAddress0,
	input MemoryMapPackage::PixelAddr pixelAddress1,
	output logic [7:0] pixel0,
	output logic [7:0] pixel1,
	output MemoryMapPackage::Word sevenSegmentOutput
);
	import MemoryMapPackage::*;

	// RAM request groups from the router
	Word mainByteAddress, mainWriteData, mainReadData;
	AccessMode mainWriteMode, mainReadMode;
	logic mainUnsignedLoad;
	Word vram0ByteAddress, vram0WriteData, vram0ReadData;
	AccessMode vram0WriteMode, vram0ReadMode;
	logic vram0UnsignedLoad;
	Word vram1ByteAddress, vram1WriteData, vram1ReadData;
	AccessMode vram1WriteMode, vram1ReadMode;
	logic vram1UnsignedLoad;

	// Register strobes and state
	logic sevenSegWrite, resetVectorWrite, swapWrite;
	Word registerWriteData, resetVector;
	logic swapRequest, displayBuffer;
	Word msCount, usCount;

	// Display side
	logic [9:0] pixelWord0, pixelWord1;
	Word vram0Pixels, vram1Pixels;

	BusRouter router (
		.sevenSeg(sevenSegmentOutput),
		.*
	);

	WordRam #(.Words(16384)) mainRam (
		.clk(clk),
		.rst(rst),
		.byteAddress(mainByteAddress),
		.writeData(mainWriteData),
		.writeMode(mainWriteMode),
		.readMode(mainReadMode),
		.unsignedLoad(mainUnsignedLoad),
		.readData(mainReadData),
		.secondaryWordAddress(14'd0),
		.secondaryData()
	);

	WordRam #(.Words(1024)) vram0 (
		.clk(clk),
		.rst(rst),
		.byteAddress(vram0ByteAddress),
		.writeData(vram0WriteData),
		.writeMode(vram0WriteMode),
		.readMode(vram0ReadMode),
		.unsignedLoad(vram0UnsignedLoad),
		.readData(vram0ReadData),
		.secondaryWordAddress(pixelWord0),
		.secondaryData(vram0Pixels)
	);

	WordRam #(.Words(1024)) vram1 (
		.clk(clk),
		.rst(rst),
		.byteAddress(vram1ByteAddress),
		.writeData(vram1WriteData),
		.writeMode(vram1WriteMode),
		.readMode(vram1ReadMode),
		.unsignedLoad(vram1UnsignedLoad),
		.readData(vram1ReadData),
		.secondaryWordAddress(pixelWord1),
		.secondaryData(vram1Pixels)
	);

	PeripheralRegisters registers (
		.sevenSeg(sevenSegmentOutput),
		.*
	);

	TimeBase #(
		.CyclesPerMs(ClockHz / 1000),
		.CyclesPerUs(ClockHz / 1000000)
	) timeBase (
		.*
	);

	PixelFetch fetch0 (
		.clk(clk),
		.rst(rst),
		.pixelAddress(pixelAddress0),
		.displayBuffer(displayBuffer),
		.wordAddress(pixelWord0),
		.wordData(vram0Pixels),
		.pixel(pixel0)
	);

	PixelFetch fetch1 (
		.clk(clk),
		.rst(rst),
		.pixelAddress(pixelAddress1),
		.displayBuffer(displayBuffer),
		.wordAddress(pixelWord1),
		.wordData(vram1Pixels),
		.pixel(pixel1)
	);

endmodule

/* logic/PeripheralRegisters.sv */
`timescale 1ns/1ps

module PeripheralRegisters (
	input logic clk,
	input logic rst,
	input logic sevenSegWrite,
	input logic resetVectorWrite,
	input logic swapWrite,
	input MemoryMapPackage::Word registerWriteData,
	input logic frameDone,
	output MemoryMapPackage::Word sevenSeg,
	output MemoryMapPackage::Word resetVector,
	output logic swapRequest,
	output logic displayBuffer
);
	import MemoryMapPackage::*;

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			sevenSeg <= '0;
			resetVector <= ResetVectorDefault;
			swapRequest <= 1'b0;
			displayBuffer <= 1'b0;
		end
		else begin
			if (sevenSegWrite)
				sevenSeg <= registerWriteData;
			if (resetVectorWrite)
				resetVector <= registerWriteData;

			// Swap only between frames, and the pending request is consumed
			if (frameDone && swapRequest) begin
				displayBuffer <= ~displayBuffer;
				swapRequest <= 1'b0;
			end
			else if (swapWrite) begin
				swapRequest <= registerWriteData[0];
			end
		end
	end

endmodule

/* logic/PixelFetch.sv */
`timescale 1ns/1ps

module PixelFetch (
	input logic clk,
	input logic rst,
	input MemoryMapPackage::PixelAddr pixelAddress,
	input logic displayBuffer,
	output logic [9:0] wordAddress,
	input MemoryMapPackage::Word wordData,
	output logic [7:0] pixel
);
	import MemoryMapPackage::*;

	logic [1:0] byteSelQ;

	// Onscreen half on top, then the word within that half
	assign wordAddress = {displayBuffer, pixelAddress[10:2]};

	// Byte select follows the RAM by one cycle
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0)
			byteSelQ <= 2'd0;
		else
			byteSelQ <= pixelAddress[1:0];
	end

	assign pixel = wordData[{byteSelQ, 3'b000} +: 8];

endmodule

/* logic/TimeBase.sv */
`timescale 1ns/1ps

module TimeBase #(
	parameter int CyclesPerMs = 8333,
	parameter int CyclesPerUs = 8
) (
	input logic clk,
	input logic rst,
	output MemoryMapPackage::Word msCount,
	output MemoryMapPackage::Word usCount
);
	import MemoryMapPackage::*;

	// Index 0 is the millisecond tick, index 1 the microsecond tick
	localparam Word Periods [2] = '{Word'(CyclesPerMs), Word'(CyclesPerUs)};

	Word prescale [2];
	Word count [2];

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			for (int i = 0; i < 2; i++) begin
				prescale[i] <= '0;
				count[i] <= '0;
			end
		end
		else begin
			for (int i = 0; i < 2; i++) begin
				if (prescale[i] == Periods[i] - 32'd1) begin
					prescale[i] <= '0;
					count[i] <= count[i] + 32'd1;
				end
				else begin
					prescale[i] <= prescale[i] + 32'd1;
				end
			end
		end
	end

	assign msCount = count[0];
	assign usCount = count[1];

endmodule

/* logic/WordRam.sv */
`timescale 1ns/1ps

module WordRam #(
	parameter int Words = 1024,
	localparam int AddrBits = $clog2(Words)
) (
	input logic clk,
	input logic rst,
	input MemoryMapPackage::Word byteAddress,
	input MemoryMapPackage::Word writeData,
	input MemoryMapPackage::AccessMode writeMode,
	input MemoryMapPackage::AccessMode readMode,
	input logic unsignedLoad,
	output MemoryMapPackage::Word readData,
	input logic [AddrBits-1:0] secondaryWordAddress,
	output MemoryMapPackage::Word secondaryData
);
	import MemoryMapPackage::*;

	Word mem [Words];

	logic [AddrBits-1:0] wordIndex;
	Word readWordQ;
	logic [1:0] laneQ;
	AccessMode modeQ;
	logic unsignedQ;
	logic [7:0] laneByte;
	logic [15:0] laneHalf;

	assign wordIndex = byteAddress[AddrBits+1:2];

	// Lane writes plus both registered read ports
	always_ff @(posedge clk) begin
		unique case (writeMode)
			modeByte: mem[wordIndex][{byteAddress[1:0], 3'b000} +: 8] <= writeData[7:0];
			modeHalf: mem[wordIndex][{byteAddress[1], 4'b0000} +: 16] <= writeData[15:0];
			modeWord: mem[wordIndex] <= writeData;
			default: ;
		endcase
		if (readMode != modeNone)
			readWordQ <= mem[wordIndex];
		secondaryData <= mem[secondaryWordAddress];
	end

	// Remember how to format the load once the word arrives
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			laneQ <= 2'd0;
			modeQ <= modeNone;
			unsignedQ <= 1'b0;
		end
		else begin
			laneQ <= byteAddress[1:0];
			modeQ <= readMode;
			unsignedQ <= unsignedLoad;
		end
	end

	assign laneByte = readWordQ[{laneQ, 3'b000} +: 8];
	assign laneHalf = laneQ[1] ? readWordQ[31:16] : readWordQ[15:0];

	always_comb begin
		unique case (modeQ)
			modeByte: readData = unsignedQ ? {24'd0, laneByte} : {{24{laneByte[7]}}, laneByte};
			modeHalf: readData = unsignedQ ? {16'd0, laneHalf} : {{16{laneHalf[15]}}, laneHalf};
			modeWord: readData = readWordQ;
			default: readData = '0;
		endcase
	end

endmodule

/* sources.f */
logic/MemoryMapPackage.sv
logic/WordRam.sv
logic/BusRouter.sv
logic/PeripheralRegisters.sv
logic/TimeBase.sv
logic/PixelFetch.sv
logic/MemorySystem.sv
tb/MemorySystemTb.sv

/* tb/MemorySystemTb.sv */
`timescale 1ns/1ps

module MemorySystemTb;
	import MemoryMapPackage::*;

	localparam int ClockHz = 8333333;
	localparam int CyclesPerMs = ClockHz / 1000;
	localparam int CyclesPerUs = ClockHz / 1000000;
	// Main RAM bytes covered by the software model
	localparam int RamWindow = 256;
	localparam int SwapTimeout = 20;
	localparam int TimeSteps = 6;
	localparam int StepCycles = 3000;

	typedef struct {
		Word address;
		Word writeData;
		AccessMode writeMode;
		AccessMode readMode;
		logic unsignedLoad;
		Word expected;
	} BusEntry;

	logic clk = 1'b0;
	logic rst;
	Word address;
	Word writeData;
	AccessMode writeMode;
	AccessMode readMode;
	logic unsignedLoad;
	Word dataOut;
	logic frameDone;
	PixelAddr pixelAddress0;
	PixelAddr pixelAddress1;
	logic [7:0] pixel0;
	logic [7:0] pixel1;
	Word sevenSegmentOutput;

	BusEntry busTable[$];
	logic [7:0] ramModel [RamWindow];
	Word expectedSevenSeg;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	// Rising edges since reset was released
	int cycles = 0;

	MemorySystem DUT (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (rst == 1'b1)
			cycles <= cycles + 1;
	end

	task automatic checkWord(input string what, input Word actual, input Word expected,
			input int slack);
		longint diff;
		checks++;
		diff = longint'(actual) - longint'(expected);
		if ($isunknown(actual) || diff < -slack || diff > slack) begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkPixel(input string what, input logic [7:0] actual,
			input logic [7:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// One request, then idle; the response is taken mid-cycle after the capturing edge
	task automatic busAccess(input Word addr, input Word data, input AccessMode wMode,
			input AccessMode rMode, input logic uns, output Word result, output int stamp);
		@(posedge clk);
		#1;
		address = addr;
		writeData = data;
		writeMode = wMode;
		readMode = rMode;
		unsignedLoad = uns;
		@(posedge clk);
		#1;
		writeMode = modeNone;
		readMode = modeNone;
		@(negedge clk);
		result = dataOut;
		stamp = cycles;
	endtask

	function automatic void addEntry(Word addr, Word data, AccessMode wMode, AccessMode rMode,
			logic uns, Word expected);
		BusEntry entry;
		entry.address = addr;
		entry.writeData = data;
		entry.writeMode = wMode;
		entry.readMode = rMode;
		entry.unsignedLoad = uns;
		entry.expected = expected;
		busTable.push_back(entry);
	endfunction

	function automatic void modelStore(int idx, Word data, AccessMode mode);
		int base;
		base = idx & ~3;
		case (mode)
			modeByte: ramModel[idx] = data[7:0];
			modeHalf: begin
				base = base + (idx & 2);
				ramModel[base] = data[7:0];
				ramModel[base + 1] = data[15:8];
			end
			modeWord: begin
				for (int k = 0; k < 4; k++)
					ramModel[base + k] = data[8*k +: 8];
			end
			default: ;
		endcase
	endfunction

	function automatic Word modelLoad(int idx, AccessMode mode, logic uns);
		int base;
		Word whole;
		logic [7:0] lane;
		logic [15:0] half;
		base = idx & ~3;
		whole = {ramModel[base + 3], ramModel[base + 2], ramModel[base + 1], ramModel[base]};
		lane = ramModel[idx];
		half = (idx & 2) ? whole[31:16] : whole[15:0];
		case (mode)
			modeByte: return uns ? {24'd0, lane} : {{24{lane[7]}}, lane};
			modeHalf: return uns ? {16'd0, half} : {{16{half[15]}}, half};
			default: return whole;
		endcase
	endfunction

	function automatic void buildTable();
		int idx;
		Word data;
		AccessMode mode;
		AccessMode loadMode;
		Word vectorValue;
		// Reset state, and a cycle with no read on a nonzero register
		addEntry(ResetVectorAddr, '0, modeNone, modeWord, 1'b0, ResetVectorDefault);
		addEntry(BufferSwapAddr, '0, modeNone, modeWord, 1'b0, '0);
		addEntry(ResetVectorAddr, '0, modeNone, modeNone, 1'b0, '0);
		// Registers take the whole word whatever the mode
		expectedSevenSeg = $urandom;
		addEntry(SevenSegAddr, expectedSevenSeg, modeByte, modeNone, 1'b0, '0);
		addEntry(SevenSegAddr, '0, modeNone, modeWord, 1'b0, expectedSevenSeg);
		vectorValue = $urandom;
		addEntry(ResetVectorAddr, vectorValue, modeHalf, modeNone, 1'b0, '0);
		addEntry(ResetVectorAddr, '0, modeNone, modeWord, 1'b0, vectorValue);
		// Keyboard range and an unmapped hole
		addEntry(32'd100, $urandom, modeWord, modeNone, 1'b0, '0);
		addEntry(32'd100, '0, modeNone, modeWord, 1'b0, '0);
		addEntry(32'd300, '0, modeNone, modeWord, 1'b0, '0);
		for (int i = 0; i < RamWindow / 4; i++) begin
			data = $urandom;
			modelStore(4 * i, data, modeWord);
			addEntry(MainRamBase + 4 * i, data, modeWord, modeNone, 1'b0, '0);
		end
		for (int i = 0; i < 40; i++) begin
			idx = $urandom_range(RamWindow - 1, 0);
			mode = (i % 3 == 0) ? modeByte : (i % 3 == 1) ? modeHalf : modeWord;
			data = $urandom;
			modelStore(idx, data, mode);
			addEntry(MainRamBase + idx, data, mode, modeNone, 1'b0, '0);
			// Every size, signed then unsigned
			for (int r = 0; r < 5; r++) begin
				loadMode = (r < 2) ? modeByte : (r < 4) ? modeHalf : modeWord;
				addEntry(MainRamBase + idx, '0, modeNone, loadMode, r[0],
					modelLoad(idx, loadMode, r[0]));
			end
		end
	endfunction

	task automatic pulseFrame();
		@(posedge clk);
		#1;
		frameDone = 1'b1;
		@(posedge clk);
		#1;
		frameDone = 1'b0;
	endtask

	task automatic waitSwapClear();
		Word result;
		int stamp;
		int tries;
		tries = 0;
		result = 32'd1;
		while (result !== 32'd0 && tries < SwapTimeout) begin
			busAccess(BufferSwapAddr, '0, modeNone, modeWord, 1'b0, result, stamp);
			tries++;
		end
		if (result !== 32'd0) begin
			timeouts++;
			$display("Timeout: swap request still set %0d reads after frameDone", SwapTimeout);
		end
	endtask

	task automatic writeVrams(input Word words0 [4], input Word words1 [4]);
		Word result;
		int stamp;
		for (int k = 0; k < 4; k++) begin
			busAccess(Vram0Base + 4 * k, words0[k], modeWord, modeNone, 1'b0, result, stamp);
			busAccess(Vram1Base + 4 * k, words1[k], modeWord, modeNone, 1'b0, result, stamp);
		end
	endtask

	// Pixel address goes in at one edge, byte is ready after the next
	task automatic comparePixels(input Word words0 [4], input Word words1 [4], input string when);
		for (int p = 0; p < 16; p++) begin
			@(posedge clk);
			#1;
			pixelAddress0 = PixelAddr'(p);
			pixelAddress1 = PixelAddr'(p);
			@(posedge clk);
			@(negedge clk);
			checkPixel($sformatf("pixel0 %s at %0d", when, p), pixel0,
				words0[p / 4][8*(p % 4) +: 8]);
			checkPixel($sformatf("pixel1 %s at %0d", when, p), pixel1,
				words1[p / 4][8*(p % 4) +: 8]);
		end
	endtask

	task automatic runDoubleBuffer();
		Word frontA0 [4];
		Word frontA1 [4];
		Word backB0 [4];
		Word backB1 [4];
		Word result;
		int stamp;
		for (int k = 0; k < 4; k++) begin
			frontA0[k] = $urandom;
			frontA1[k] = $urandom;
			backB0[k] = $urandom;
			backB1[k] = $urandom;
		end
		// Bring a known frame onscreen first
		writeVrams(frontA0, frontA1);
		busAccess(BufferSwapAddr, 32'd1, modeWord, modeNone, 1'b0, result, stamp);
		pulseFrame();
		waitSwapClear();
		comparePixels(frontA0, frontA1, "first frame");
		writeVrams(backB0, backB1);
		comparePixels(frontA0, frontA1, "after offscreen writes");
		busAccess(BufferSwapAddr, 32'd1, modeWord, modeNone, 1'b0, result, stamp);
		busAccess(BufferSwapAddr, '0, modeNone, modeWord, 1'b0, result, stamp);
		checkWord("swap request pending", result, 32'd1, 0);
		comparePixels(frontA0, frontA1, "while swap pending");
		pulseFrame();
		waitSwapClear();
		comparePixels(backB0, backB1, "after swap");
		pulseFrame();
		comparePixels(backB0, backB1, "after idle frameDone");
		busAccess(BufferSwapAddr, '0, modeNone, modeWord, 1'b0, result, stamp);
		checkWord("swap request after idle frameDone", result, '0, 0);
	endtask

	task automatic runTimeBase();
		Word result;
		Word ms0;
		Word us0;
		Word lastMs;
		Word lastUs;
		int stamp;
		int msStamp0;
		int usStamp0;
		int idle;
		// These writes must not disturb the counters
		busAccess(MsCounterAddr, 32'hFFFF_FF00, modeWord, modeNone, 1'b0, result, stamp);
		busAccess(UsCounterAddr, 32'hFFFF_FF00, modeWord, modeNone, 1'b0, result, stamp);
		busAccess(MsCounterAddr, '0, modeNone, modeWord, 1'b0, ms0, msStamp0);
		checkWord("msCount since reset", ms0, Word'(msStamp0 / CyclesPerMs), 1);
		busAccess(UsCounterAddr, '0, modeNone, modeWord, 1'b0, us0, usStamp0);
		checkWord("usCount since reset", us0, Word'(usStamp0 / CyclesPerUs), 1);
		lastMs = ms0;
		lastUs = us0;
		for (int step = 0; step < TimeSteps; step++) begin
			idle = 0;
			while (idle < StepCycles) begin
				@(posedge clk);
				idle++;
			end
			busAccess(MsCounterAddr, '0, modeNone, modeWord, 1'b0, result, stamp);
			checkWord("msCount progress", result - ms0,
				Word'((stamp - msStamp0) / CyclesPerMs), 1);
			if (result < lastMs) begin
				errors++;
				$display("FAILED at %0t: msCount fell from %0d to %0d", $time, lastMs, result);
			end
			lastMs = result;
			busAccess(UsCounterAddr, '0, modeNone, modeWord, 1'b0, result, stamp);
			checkWord("usCount progress", result - us0,
				Word'((stamp - usStamp0) / CyclesPerUs), 1);
			if (result < lastUs) begin
				errors++;
				$display("FAILED at %0t: usCount fell from %0d to %0d", $time, lastUs, result);
			end
			lastUs = result;
		end
	endtask

	initial begin
		Word result;
		int stamp;
		void'($urandom(32'hbcc3));
		rst = 1'b0;
		address = '0;
		writeData = '0;
		writeMode = modeNone;
		readMode = modeNone;
		unsignedLoad = 1'b0;
		frameDone = 1'b0;
		pixelAddress0 = '0;
		pixelAddress1 = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b1;
		checkWord("sevenSegmentOutput after reset", sevenSegmentOutput, '0, 0);

		buildTable();
		foreach (busTable[i]) begin
			busAccess(busTable[i].address, busTable[i].writeData, busTable[i].writeMode,
				busTable[i].readMode, busTable[i].unsignedLoad, result, stamp);
			checkWord($sformatf("dataOut for entry %0d", i), result, busTable[i].expected, 0);
		end
		checkWord("sevenSegmentOutput", sevenSegmentOutput, expectedSevenSeg, 0);

		runDoubleBuffer();
		runTimeBase();

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
